//--- aud_mem_pkg.sv
package aud_mem_pkg;

	// one signed audio word as stored in SRAM
	typedef logic signed [15:0] sample_t;

	// SRAM word address
	typedef logic [19:0] addr_t;

	// request from one SRAM master
	// we is active high here, the pin is active low
	typedef struct packed {
		addr_t   addr;
		sample_t wdata;
		logic    we;
	} sram_req_t;

endpackage

//--- aud_ctrl_pkg.sv
package aud_ctrl_pkg;

	// operating mode, also shown on the display
	typedef enum logic [2:0] {
		MODE_STOP       = 3'd0,
		MODE_RECD       = 3'd1,
		MODE_RECD_PAUSE = 3'd2,
		MODE_PLAY       = 3'd3,
		MODE_PLAY_PAUSE = 3'd4
	} mode_e;

	// playback speed stage
	typedef enum logic [1:0] {
		SPD_NORMAL = 2'd0,
		SPD_FAST   = 2'd1,
		SPD_HOLD   = 2'd2,
		SPD_LINEAR = 2'd3
	} speed_mode_e;

	// factor field f gives N = f + 1
	typedef struct packed {
		speed_mode_e mode;
		logic [2:0]  factor;
	} speed_t;

endpackage

//--- aud_recorder.sv
`timescale 1ns/1ps

module aud_recorder import aud_mem_pkg::*; #(
	parameter int MEM_DEPTH = 1048576
) (
	input  logic      i_AUD_BCLK,
	input  logic      i_rst_n,
	input  logic      i_adclrck,
	input  logic      i_adcdat,
	input  logic      i_run,
	input  logic      i_clear,
	input  logic      i_stop,
	output sram_req_t o_req,
	output addr_t     o_len,
	output logic      o_done
);

	logic        lrck_d;
	logic        left_start;
	logic [4:0]  bit_cnt;
	sample_t     shreg;
	logic [20:0] wr_addr;
	logic        wr_pend;
	logic        wr_en;

	// lrck seen low for the first time
	assign left_start = lrck_d & ~i_adclrck;

	// a pause or stop landing on the write cycle drops that word
	assign wr_en = wr_pend & i_run;

	assign o_req = '{addr: wr_addr[19:0], wdata: shreg, we: wr_en};

	// bits arrive msb first on the edges after left_start
	always_ff @(posedge i_AUD_BCLK) begin
		if (bit_cnt < 5'd16) begin
			shreg <= {shreg[14:0], i_adcdat};
		end
	end

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			lrck_d  <= 1'b0;
			bit_cnt <= 5'd16;
			wr_pend <= 1'b0;
			wr_addr <= '0;
			o_len   <= '0;
			o_done  <= 1'b0;
		end else begin
			lrck_d <= i_adclrck;
			o_done <= 1'b0;

			if (i_stop) begin
				bit_cnt <= 5'd16;
			end else if (left_start) begin
				bit_cnt <= 5'd0;
			end else if (bit_cnt < 5'd16) begin
				bit_cnt <= bit_cnt + 5'd1;
			end

			// 16th bit shifts in on this edge
			wr_pend <= !i_stop && !left_start && (bit_cnt == 5'd15) && i_run &&
				(wr_addr < MEM_DEPTH);

			if (i_clear) begin
				wr_addr <= '0;
			end else if (wr_en) begin
				wr_addr <= wr_addr + 21'd1;
				o_done  <= (wr_addr == 21'(MEM_DEPTH - 1));
			end

			// a full 2^20 recording saturates one word short
			if (i_stop) begin
				o_len <= wr_addr[20] ? '1 : wr_addr[19:0];
			end
		end
	end

	a_addr_bound: assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		wr_addr <= MEM_DEPTH);

endmodule

//--- aud_dsp.sv
`timescale 1ns/1ps

module aud_dsp import aud_mem_pkg::*, aud_ctrl_pkg::*; #(
	parameter int MEM_DEPTH = 1048576
) (
	input  logic      i_AUD_BCLK,
	input  logic      i_rst_n,
	input  logic      i_daclrck,
	input  logic      i_run,
	input  logic      i_clear,
	input  speed_t    i_speed,
	input  addr_t     i_rec_len,
	input  sample_t   i_sram_rdata,
	output sram_req_t o_req,
	output sample_t   o_sample,
	output logic      o_done
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_RD0,
		S_RD1,
		S_DIV,
		S_FIN
	} state_e;

	state_e             state;
	logic               lrck_d;
	logic               right_start;
	logic [20:0]        k;
	logic [2:0]         j;
	speed_t             spd_r;
	logic [3:0]         n;
	logic [20:0]        len_lim;
	addr_t              rd_addr;
	logic [4:0]         div_cnt;
	sample_t            s0;
	logic [2:0]         j_eff;
	logic signed [16:0] diff;
	logic signed [20:0] prod;
	logic [3:0]         div_rem;
	logic [19:0]        div_quo;
	logic               div_neg;
	logic [4:0]         div_trial;
	logic signed [16:0] q_s;
	logic signed [16:0] interp;

	assign right_start = ~lrck_d & i_daclrck;
	assign n = {1'b0, spd_r.factor} + 4'd1;

	// never read past what the memory can hold
	assign len_lim = ({1'b0, i_rec_len} > 21'(MEM_DEPTH)) ? 21'(MEM_DEPTH) :
		{1'b0, i_rec_len};

	assign o_req = '{addr: rd_addr, wdata: '0, we: 1'b0};

	// interpolation term, zero weight outside linear mode
	assign j_eff = (spd_r.mode == SPD_LINEAR) ? j : 3'd0;
	assign diff = {i_sram_rdata[15], i_sram_rdata} - {s0[15], s0};
	assign prod = diff * $signed({1'b0, j_eff});

	// restoring divide by N on the magnitude
	assign div_trial = {div_rem, div_quo[19]};
	assign q_s = div_neg ? -$signed({1'b0, div_quo[15:0]}) : $signed({1'b0, div_quo[15:0]});
	assign interp = {s0[15], s0} + q_s;

	always_ff @(posedge i_AUD_BCLK) begin
		case (state)
			S_RD0: s0 <= i_sram_rdata;
			S_RD1: begin
				div_rem <= '0;
				div_neg <= prod[20];
				div_quo <= prod[20] ? 20'(-prod) : prod[19:0];
			end
			S_DIV: begin
				if (div_trial >= {1'b0, n}) begin
					div_rem <= 4'(div_trial - {1'b0, n});
					div_quo <= {div_quo[18:0], 1'b1};
				end else begin
					div_rem <= div_trial[3:0];
					div_quo <= {div_quo[18:0], 1'b0};
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			state    <= S_IDLE;
			lrck_d   <= 1'b0;
			k        <= '0;
			j        <= '0;
			spd_r    <= '{mode: SPD_NORMAL, factor: 3'd0};
			rd_addr  <= '0;
			div_cnt  <= '0;
			o_sample <= '0;
			o_done   <= 1'b0;
		end else begin
			lrck_d <= i_daclrck;
			o_done <= 1'b0;
			if (i_clear) begin
				state    <= S_IDLE;
				k        <= '0;
				j        <= '0;
				o_sample <= '0;
			end else begin
				case (state)
					S_IDLE: begin
						if (right_start) begin
							if (!i_run) begin
								o_sample <= '0;
							end else if (k >= len_lim) begin
								// last sample already went out
								o_done   <= 1'b1;
								o_sample <= '0;
							end else begin
								spd_r   <= i_speed;
								rd_addr <= k[19:0];
								state   <= S_RD0;
							end
						end
					end
					S_RD0: begin
						// last index reads itself again, so s[k+1] = s[k]
						rd_addr <= (k + 21'd1 < len_lim) ? 20'(k + 21'd1) : k[19:0];
						state   <= S_RD1;
					end
					S_RD1: begin
						div_cnt <= 5'd19;
						state   <= S_DIV;
					end
					S_DIV: begin
						div_cnt <= div_cnt - 5'd1;
						if (div_cnt == 5'd0) begin
							state <= S_FIN;
						end
					end
					S_FIN: begin
						o_sample <= interp[15:0];
						case (spd_r.mode)
							SPD_NORMAL: k <= k + 21'd1;
							SPD_FAST:   k <= k + {17'd0, n};
							default: begin
								if (j >= spd_r.factor) begin
									j <= 3'd0;
									k <= k + 21'd1;
								end else begin
									j <= j + 3'd1;
								end
							end
						endcase
						state <= S_IDLE;
					end
					default: state <= S_IDLE;
				endcase
			end
		end
	end

	a_rd_in_range: assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		(i_run && (state == S_RD0 || state == S_RD1)) |-> (o_req.addr < i_rec_len));

endmodule

//--- aud_player.sv
`timescale 1ns/1ps

module aud_player import aud_mem_pkg::*; (
	input  logic    i_AUD_BCLK,
	input  logic    i_rst_n,
	input  logic    i_daclrck,
	input  sample_t i_sample,
	output logic    o_AUD_DACDAT
);

	logic       lrck_d;
	logic       left_start;
	logic [4:0] bit_cnt;
	sample_t    shreg;

	assign left_start = lrck_d & ~i_daclrck;

	// remaining bits after the msb
	always_ff @(posedge i_AUD_BCLK) begin
		if (left_start) begin
			shreg <= {i_sample[14:0], 1'b0};
		end else if (bit_cnt < 5'd16) begin
			shreg <= {shreg[14:0], 1'b0};
		end
	end

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			lrck_d       <= 1'b0;
			bit_cnt      <= 5'd16;
			o_AUD_DACDAT <= 1'b0;
		end else begin
			lrck_d <= i_daclrck;
			if (left_start) begin
				// msb valid for the next sampling edge
				bit_cnt      <= 5'd1;
				o_AUD_DACDAT <= i_sample[15];
			end else if (bit_cnt < 5'd16) begin
				bit_cnt      <= bit_cnt + 5'd1;
				o_AUD_DACDAT <= shreg[15];
			end else begin
				// idle bits and the whole right phase
				o_AUD_DACDAT <= 1'b0;
			end
		end
	end

endmodule

//--- aud_ctrl.sv
`timescale 1ns/1ps

module aud_ctrl import aud_mem_pkg::*, aud_ctrl_pkg::*; (
	input  logic      i_AUD_BCLK,
	input  logic      i_rst_n,
	input  logic [2:0] i_key,
	input  logic      i_rec_done,
	input  logic      i_play_done,
	input  sram_req_t i_rec_req,
	input  sram_req_t i_play_req,
	output mode_e     o_mode,
	output logic      o_rec_run,
	output logic      o_rec_clear,
	output logic      o_rec_stop,
	output logic      o_play_run,
	output logic      o_play_clear,
	output sram_req_t o_sram_req
);

	logic [2:0] key_r;
	logic [2:0] key_d;
	logic [2:0] key_fall;
	mode_e      mode_r;
	mode_e      mode_w;
	logic       rec_clr_w;
	logic       play_clr_w;

	// keys are active low, a press is a falling edge
	assign key_fall = key_d & ~key_r;

	always_comb begin
		mode_w     = mode_r;
		rec_clr_w  = 1'b0;
		play_clr_w = 1'b0;
		if (i_rec_done || i_play_done || key_fall[2]) begin
			mode_w = MODE_STOP;
		end else begin
			case (mode_r)
				MODE_STOP: begin
					if (key_fall[0]) begin
						mode_w    = MODE_RECD;
						rec_clr_w = 1'b1;
					end else if (key_fall[1]) begin
						mode_w     = MODE_PLAY;
						play_clr_w = 1'b1;
					end
				end
				MODE_RECD:       if (key_fall[0]) mode_w = MODE_RECD_PAUSE;
				MODE_RECD_PAUSE: if (key_fall[0]) mode_w = MODE_RECD;
				MODE_PLAY:       if (key_fall[1]) mode_w = MODE_PLAY_PAUSE;
				MODE_PLAY_PAUSE: if (key_fall[1]) mode_w = MODE_PLAY;
				default:         mode_w = MODE_STOP;
			endcase
		end
	end

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			key_r        <= 3'b111;
			key_d        <= 3'b111;
			mode_r       <= MODE_STOP;
			o_rec_clear  <= 1'b0;
			o_play_clear <= 1'b0;
		end else begin
			key_r        <= i_key;
			key_d        <= key_r;
			mode_r       <= mode_w;
			o_rec_clear  <= rec_clr_w;
			o_play_clear <= play_clr_w;
		end
	end

	assign o_mode     = mode_r;
	assign o_rec_run  = (mode_r == MODE_RECD);
	assign o_rec_stop = (mode_r == MODE_STOP);
	assign o_play_run = (mode_r == MODE_PLAY);

	// recorder owns the bus only while recording
	assign o_sram_req = (mode_r == MODE_RECD) ? i_rec_req : i_play_req;

	a_we_only_recd: assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		o_sram_req.we |-> (mode_r == MODE_RECD));

endmodule

//--- aud_top.sv
`timescale 1ns/1ps

module aud_top import aud_mem_pkg::*, aud_ctrl_pkg::*; #(
	parameter int MEM_DEPTH = 1048576
) (
	input  logic    i_AUD_BCLK,
	input  logic    i_rst_n,
	input  logic    i_key_0,
	input  logic    i_key_1,
	input  logic    i_key_2,
	input  speed_t  i_speed,
	input  logic    i_AUD_ADCLRCK,
	input  logic    i_AUD_ADCDAT,
	input  logic    i_AUD_DACLRCK,
	output logic    o_AUD_DACDAT,
	output addr_t   o_SRAM_ADDR,
	output sample_t o_SRAM_DQ_WR,
	input  sample_t i_SRAM_DQ_RD,
	output logic    o_SRAM_WE_N,
	output mode_e   o_mode
);

	logic      rec_run;
	logic      rec_clear;
	logic      rec_stop;
	logic      rec_done;
	addr_t     rec_len;
	sram_req_t rec_req;
	logic      play_run;
	logic      play_clear;
	logic      play_done;
	sram_req_t play_req;
	sram_req_t sram_req;
	sample_t   dac_sample;

	assign o_SRAM_ADDR  = sram_req.addr;
	assign o_SRAM_DQ_WR = sram_req.wdata;
	assign o_SRAM_WE_N  = ~sram_req.we;

	aud_ctrl u_ctrl (
		.i_AUD_BCLK  (i_AUD_BCLK),
		.i_rst_n     (i_rst_n),
		.i_key       ({i_key_2, i_key_1, i_key_0}),
		.i_rec_done  (rec_done),
		.i_play_done (play_done),
		.i_rec_req   (rec_req),
		.i_play_req  (play_req),
		.o_mode      (o_mode),
		.o_rec_run   (rec_run),
		.o_rec_clear (rec_clear),
		.o_rec_stop  (rec_stop),
		.o_play_run  (play_run),
		.o_play_clear(play_clear),
		.o_sram_req  (sram_req)
	);

	aud_recorder #(.MEM_DEPTH(MEM_DEPTH)) u_recorder (
		.i_AUD_BCLK(i_AUD_BCLK),
		.i_rst_n   (i_rst_n),
		.i_adclrck (i_AUD_ADCLRCK),
		.i_adcdat  (i_AUD_ADCDAT),
		.i_run     (rec_run),
		.i_clear   (rec_clear),
		.i_stop    (rec_stop),
		.o_req     (rec_req),
		.o_len     (rec_len),
		.o_done    (rec_done)
	);

	aud_dsp #(.MEM_DEPTH(MEM_DEPTH)) u_dsp (
		.i_AUD_BCLK  (i_AUD_BCLK),
		.i_rst_n     (i_rst_n),
		.i_daclrck   (i_AUD_DACLRCK),
		.i_run       (play_run),
		.i_clear     (play_clear),
		.i_speed     (i_speed),
		.i_rec_len   (rec_len),
		.i_sram_rdata(i_SRAM_DQ_RD),
		.o_req       (play_req),
		.o_sample    (dac_sample),
		.o_done      (play_done)
	);

	aud_player u_player (
		.i_AUD_BCLK  (i_AUD_BCLK),
		.i_rst_n     (i_rst_n),
		.i_daclrck   (i_AUD_DACLRCK),
		.i_sample    (dac_sample),
		.o_AUD_DACDAT(o_AUD_DACDAT)
	);

endmodule

//--- tb_sram_model.sv
`timescale 1ns/1ps

module tb_sram_model import aud_mem_pkg::*; #(
	parameter int DEPTH = 64
) (
	input  logic    i_AUD_BCLK,
	input  addr_t   i_addr,
	input  sample_t i_wdata,
	input  logic    i_we_n,
	output sample_t o_rdata
);

	localparam int AW = $clog2(DEPTH);

	sample_t mem [DEPTH];
	logic    in_range;

	// every word starts with its own address scrambled in
	initial begin
		for (int a = 0; a < DEPTH; a++) begin
			mem[a] = sample_t'((a * 40503) ^ 32'h5a5a);
		end
	end

	assign in_range = (i_addr < addr_t'(DEPTH));

	// read data follows the address without a clock
	assign o_rdata = in_range ? mem[i_addr[AW-1:0]] : '0;

	always @(posedge i_AUD_BCLK) begin
		if (!i_we_n && in_range) begin
			mem[i_addr[AW-1:0]] <= i_wdata;
		end
	end

endmodule

//--- tb_aud_top.sv
`timescale 1ns/1ps

module tb_aud_top import aud_mem_pkg::*, aud_ctrl_pkg::*; ();

	localparam int DEPTH = 48;

	logic       clk = 1'b0;
	logic       rst;
	logic [2:0] key;
	speed_t     speed;
	logic       lrck;
	logic       adcdat;
	logic       dacdat;
	addr_t      sram_addr;
	sample_t    sram_wdata;
	sample_t    sram_rdata;
	logic       sram_we_n;
	mode_e      mode;

	integer     seed;
	int         ph;
	sample_t    cur;
	logic       rec_on;
	sample_t    exp_q[$];
	sample_t    rec_q[$];
	sample_t    untouched;

	int         cap_pos;
	logic       lrck_prev;
	sample_t    cap_shift;
	sample_t    cap_word;
	event       frame_ev;

	logic       play_chk;
	string      test_name;
	speed_t     cur_spd;
	int         exp_n;
	int         out_idx;
	int         silent;
	int         val_err;
	int         to_err;

	aud_top #(.MEM_DEPTH(DEPTH)) u_dut (
		.i_AUD_BCLK   (clk),
		.i_rst_n      (rst),
		.i_key_0      (key[0]),
		.i_key_1      (key[1]),
		.i_key_2      (key[2]),
		.i_speed      (speed),
		.i_AUD_ADCLRCK(lrck),
		.i_AUD_ADCDAT (adcdat),
		.i_AUD_DACLRCK(lrck),
		.o_AUD_DACDAT (dacdat),
		.o_SRAM_ADDR  (sram_addr),
		.o_SRAM_DQ_WR (sram_wdata),
		.i_SRAM_DQ_RD (sram_rdata),
		.o_SRAM_WE_N  (sram_we_n),
		.o_mode       (mode)
	);

	tb_sram_model #(.DEPTH(64)) u_sram (
		.i_AUD_BCLK(clk),
		.i_addr    (sram_addr),
		.i_wdata   (sram_wdata),
		.i_we_n    (sram_we_n),
		.o_rdata   (sram_rdata)
	);

	always #4 clk = ~clk;

	// expected output count for a recording of len words
	function automatic int ref_count(input int len, input speed_t spd);
		int n;
		n = int'(spd.factor) + 1;
		case (spd.mode)
			SPD_NORMAL: return len;
			SPD_FAST:   return (len + n - 1) / n;
			default:    return len * n;
		endcase
	endfunction

	// output number idx of the speed stage
	function automatic sample_t ref_sample(input sample_t q[$], input speed_t spd, input int idx);
		int n;
		int k;
		int j;
		int a;
		int b;
		n = int'(spd.factor) + 1;
		case (spd.mode)
			SPD_NORMAL: return q[idx];
			SPD_FAST:   return q[idx * n];
			SPD_HOLD:   return q[idx / n];
			default: begin
				k = idx / n;
				j = idx % n;
				a = q[k];
				b = (k + 1 < q.size()) ? q[k + 1] : a;
				// int division truncates toward zero
				return sample_t'(a + ((b - a) * j) / n);
			end
		endcase
	endfunction

	// codec side, both lrck lines share one 64 bit frame
	always @(posedge clk) begin
		if (ph == 0) begin
			lrck <= 1'b0;
			cur = sample_t'($random(seed));
			if (rec_on) begin
				exp_q.push_back(cur);
			end
		end else if (ph == 32) begin
			lrck <= 1'b1;
		end
		if (ph >= 1 && ph <= 16) begin
			adcdat <= cur[16 - ph];
		end else begin
			adcdat <= 1'b0;
		end
		ph <= (ph + 1) % 64;
	end

	// dac bits are stable around the falling edge
	always @(negedge clk) begin
		if (lrck_prev && !lrck) begin
			cap_pos = 0;
		end else if (cap_pos < 40) begin
			cap_pos++;
		end
		if (cap_pos >= 1 && cap_pos <= 16) begin
			cap_shift = {cap_shift[14:0], dacdat};
		end
		if (cap_pos == 16) begin
			cap_word = cap_shift;
			-> frame_ev;
		end
		lrck_prev = lrck;
	end

	always @(frame_ev) begin
		sample_t e;
		if (play_chk) begin
			e = (out_idx < exp_n) ? ref_sample(rec_q, cur_spd, out_idx) : '0;
			// up to two leading silent frames are allowed
			if (out_idx == 0 && silent < 2 && cap_word == '0 && e != '0) begin
				silent++;
			end else begin
				if (cap_word !== e) begin
					$display("Fail %s frame %0d: expected %h, actual %h",
						test_name, out_idx, e, cap_word);
					val_err++;
				end
				if (out_idx < exp_n) begin
					out_idx++;
				end
			end
		end
	end

	task automatic wait_phase(input int p);
		int n;
		n = 0;
		@(posedge clk);
		while (ph != p && n < 200) begin
			@(posedge clk);
			n++;
		end
		if (ph != p) begin
			$display("timeout: frame position %0d never came", p);
			to_err++;
		end
	endtask

	task automatic wait_mode(input mode_e m, input int limit);
		int n;
		n = 0;
		while (mode !== m && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (mode !== m) begin
			$display("timeout: mode did not reach %s in %s", m.name(), test_name);
			to_err++;
		end
	endtask

	task automatic wait_samples(input int cnt);
		int n;
		n = 0;
		@(posedge clk);
		while (exp_q.size() < cnt && n < cnt * 64 + 256) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() < cnt) begin
			$display("timeout: only %0d of %0d samples were sent", exp_q.size(), cnt);
			to_err++;
		end
	endtask

	// keys go down in the right phase, far from the write cycle
	task automatic press_key(input int idx);
		wait_phase(40);
		key[idx] <= 1'b0;
		repeat (4) @(posedge clk);
		key[idx] <= 1'b1;
	endtask

	task automatic check_mem();
		for (int i = 0; i < exp_q.size(); i++) begin
			if (u_sram.mem[i] !== exp_q[i]) begin
				$display("Fail %s addr %0d: expected %h, actual %h",
					test_name, i, exp_q[i], u_sram.mem[i]);
				val_err++;
			end
		end
	endtask

	task automatic run_play(input string name, input speed_t spd);
		@(posedge clk);
		speed     <= spd;
		cur_spd   = spd;
		test_name = name;
		exp_n     = ref_count(rec_q.size(), spd);
		out_idx   = 0;
		silent    = 0;
		press_key(1);
		play_chk = 1'b1;
		wait_mode(MODE_STOP, (exp_n + 6) * 64);
		play_chk = 1'b0;
		if (out_idx != exp_n) begin
			$display("Fail %s frame count: expected %0d, actual %0d", name, exp_n, out_idx);
			val_err++;
		end
	endtask

	initial begin
		seed      = 32'h27bb;
		ph        = 0;
		rec_on    = 1'b0;
		cap_pos   = 40;
		lrck_prev = 1'b1;
		cap_shift = '0;
		cap_word  = '0;
		play_chk  = 1'b0;
		test_name = "reset";
		cur_spd   = '{mode: SPD_NORMAL, factor: 3'd0};
		exp_n     = 0;
		out_idx   = 0;
		silent    = 0;
		val_err   = 0;
		to_err    = 0;
		rst       = 1'b1;
		key       = 3'b111;
		speed     = '{mode: SPD_NORMAL, factor: 3'd0};
		lrck      = 1'b1;
		adcdat    = 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		if (mode !== MODE_STOP || sram_we_n !== 1'b1 || dacdat !== 1'b0) begin
			$display("outputs are not idle after reset");
			val_err++;
		end

		// plain recording of 20 words
		test_name = "record";
		press_key(0);
		rec_on = 1'b1;
		wait_samples(20);
		press_key(2);
		rec_on = 1'b0;
		wait_mode(MODE_STOP, 16);
		check_mem();

		// pause drops words without leaving a gap
		test_name = "record pause";
		exp_q.delete();
		untouched = u_sram.mem[24];
		press_key(0);
		rec_on = 1'b1;
		wait_samples(8);
		press_key(0);
		rec_on = 1'b0;
		repeat (4) wait_phase(40);
		press_key(0);
		rec_on = 1'b1;
		wait_samples(24);
		press_key(2);
		rec_on = 1'b0;
		wait_mode(MODE_STOP, 16);
		check_mem();
		if (u_sram.mem[24] !== untouched) begin
			$display("Fail %s addr 24: expected %h, actual %h",
				test_name, untouched, u_sram.mem[24]);
			val_err++;
		end
		rec_q = exp_q;

		run_play("play normal", '{mode: SPD_NORMAL, factor: 3'd0});
		run_play("play fast x3", '{mode: SPD_FAST, factor: 3'd2});
		run_play("play hold x2", '{mode: SPD_HOLD, factor: 3'd1});
		run_play("play linear x4", '{mode: SPD_LINEAR, factor: 3'd3});

		// recording runs into the end of memory
		test_name = "fill to depth";
		exp_q.delete();
		press_key(0);
		rec_on = 1'b1;
		wait_mode(MODE_STOP, 60 * 64);
		rec_on = 1'b0;
		if (exp_q.size() != DEPTH) begin
			$display("Fail %s length: expected %0d, actual %0d", test_name, DEPTH, exp_q.size());
			val_err++;
		end
		check_mem();
		for (int i = 0; i < 192; i++) begin
			@(posedge clk);
			if (sram_we_n !== 1'b1) begin
				$display("write enable went active after the memory was full");
				val_err++;
			end
		end

		$display("errors: %0d value, %0d timeout", val_err, to_err);
		if (val_err == 0 && to_err == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- src.f
aud_mem_pkg.sv
aud_ctrl_pkg.sv
aud_recorder.sv
aud_dsp.sv
aud_player.sv
aud_ctrl.sv
aud_top.sv
tb_sram_model.sv
tb_aud_top.sv

//--- Bender.yml
package:
  name: aud_rec_play

sources:
  - aud_mem_pkg.sv
  - aud_ctrl_pkg.sv
  - aud_recorder.sv
  - aud_dsp.sv
  - aud_player.sv
  - aud_ctrl.sv
  - aud_top.sv
  - target: simulation
    files:
      - tb_sram_model.sv
      - tb_aud_top.sv
